/* addsub_unit.sv */
// Add, subtract and set-less-than unit
// One shared prefix adder; subtract and compares run as a + ~b + 1

`timescale 1ns/1ps

module addsub_unit (
    input  alu_pkg::alu_op_e        op,
    input  logic [alu_pkg::XLEN-1:0] a,
    input  logic [alu_pkg::XLEN-1:0] b,
    output logic [alu_pkg::XLEN-1:0] add_result
);
    import alu_pkg::*;

    logic            do_sub;
    logic [XLEN-1:0] b_in;
    logic [XLEN-1:0] sum;
    logic            cout;
    logic            lt_signed;
    logic            lt_unsigned;

    // Everything but ADD needs the difference
    assign do_sub = (op != OP_ADD);
    assign b_in   = do_sub ? ~b : b;

    ks_adder #(
        .N      (XLEN),
        .BYPASS (1'b0)
    ) adder0 (
        .dataa (a),
        .datab (b_in),
        .cin   (do_sub),
        .sum   (sum),
        .cout  (cout)
    );

    // No borrow out means a >= b
    assign lt_unsigned = ~cout;

    // Differing signs decide directly, else the difference sign does
    assign lt_signed = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : sum[XLEN-1];

    always_comb begin
        case (op)
            OP_ADD, OP_SUB: add_result = sum;
            OP_SLT:         add_result = XLEN'(lt_signed);
            OP_SLTU:        add_result = XLEN'(lt_unsigned);
            // Not ours
            default:        add_result = '0;
        endcase
    end

endmodule

/* alu_ctrl.sv */
// ALU control FSM
// Accepts start strobes, launches the multiplier, steers the unit
// results into the result register and drives done and busy

`timescale 1ns/1ps

module alu_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  alu_pkg::alu_op_e         op,
    input  logic [alu_pkg::XLEN-1:0] add_result,
    input  logic [alu_pkg::XLEN-1:0] sl_result,
    input  logic                     mul_done,
    input  logic [alu_pkg::XLEN-1:0] mul_result,
    output logic                     mul_start,
    output logic [alu_pkg::XLEN-1:0] result,
    output logic                     done,
    output logic                     busy
);
    import alu_pkg::*;

    ctrl_state_e     state;
    ctrl_state_e     state_next;
    logic            accept;
    logic            is_mul;
    logic [XLEN-1:0] op_result;

    // Starts dropped only while the multiplier runs
    assign accept = start && (state != ST_MUL);
    assign is_mul = (op == OP_MUL);

    // Multiplier latches operands on this same edge
    assign mul_start = accept && is_mul;

    assign busy = (state == ST_MUL);
    assign done = (state == ST_DONE);

    // Opcode class picks the unit
    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU: op_result = add_result;
            default:                         op_result = sl_result;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE, ST_DONE: begin
                // A start in the done cycle chains straight on
                if (!accept) begin
                    state_next = ST_IDLE;
                end else if (is_mul) begin
                    state_next = ST_MUL;
                end else begin
                    state_next = ST_DONE;
                end
            end
            ST_MUL: begin
                if (mul_done) begin
                    state_next = ST_DONE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            result <= '0;
        end else begin
            state <= state_next;
            // Single-cycle ops land at the accepting edge
            if (accept && !is_mul) begin
                result <= op_result;
            end else if ((state == ST_MUL) && mul_done) begin
                result <= mul_result;
            end
        end
    end

endmodule

/* alu_pkg.sv */
// Integer ALU shared definitions
// Operand width, opcode set and control FSM states used across the
// execution unit and its datapath blocks

package alu_pkg;

    // Operand and result width
    localparam int XLEN = 32;

    // Shift amount width, log2 of XLEN
    localparam int SHAMT_W = $clog2(XLEN);

    // Opcodes accepted on the start strobe
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_SLT  = 4'd2,
        OP_SLTU = 4'd3,
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_SLL  = 4'd7,
        OP_SRL  = 4'd8,
        OP_SRA  = 4'd9,
        OP_MUL  = 4'd10
    } alu_op_e;

    // Control FSM states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        // Waiting on the iterative multiplier
        ST_MUL  = 2'd1,
        // Result register holds a fresh value
        ST_DONE = 2'd2
    } ctrl_state_e;

endpackage

/* files.f */
alu_pkg.sv
ks_adder.sv
addsub_unit.sv
shift_logic_unit.sv
mul_unit.sv
alu_ctrl.sv
int_alu_top.sv
int_alu_assert.sv
int_alu_tb.sv

/* int_alu_assert.sv */
// ALU control strobe assertions
// Bound into alu_ctrl, watches start, done, busy and mul_start

`timescale 1ns/1ps

module alu_ctrl_assert (
    input logic             clk,
    input logic             rst,
    input logic             start,
    input alu_pkg::alu_op_e op,
    input logic             mul_start,
    input logic             done,
    input logic             busy
);
    import alu_pkg::*;

    // done drops unless a new request chains on in the done cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        (done && !start) |=> !done)
        else $error("done held high without a chained start");

    // Single-cycle ops present their result one cycle after acceptance
    a_done_latency: assert property (@(posedge clk) disable iff (rst)
        (start && !busy && (op != OP_MUL)) |=> done)
        else $error("done missing one cycle after accepted start");

    // Busy hands over to exactly one of busy or done
    a_busy_done: assert property (@(posedge clk) disable iff (rst)
        busy |=> (busy ^ done))
        else $error("busy did not end cleanly into done");

    // Multiplier launched only from an idle unit that then goes busy
    a_mul_start: assert property (@(posedge clk) disable iff (rst)
        mul_start |-> !busy ##1 busy)
        else $error("mul_start while busy or without busy following");

endmodule

bind alu_ctrl alu_ctrl_assert ctrl_chk0 (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .op        (op),
    .mul_start (mul_start),
    .done      (done),
    .busy      (busy)
);

/* int_alu_tb.sv */
// Integer ALU testbench
// Directed tests for add/sub, compares, logic, shifts and multiply,
// plus busy and chaining behavior, against a plain-operator model

`timescale 1ns/1ps

module int_alu_tb;
    import alu_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int unsigned SEED         = 32'h6efe8f64;
    localparam int          NUM_RAND     = 24;
    localparam int          NUM_MUL_RAND = 8;
    // Longest legal wait for done, with slack
    localparam int          MAX_WAIT     = 2 * XLEN + 8;
    // Negedges from the request cycle to done for a multiply
    // done rises XLEN+1 edges after the accepting edge
    localparam int          MUL_LATENCY  = XLEN + 2;

    // Cycle budget per test, for the watchdog
    localparam int RESET_CYCLES = 12;
    localparam int OP_CYCLES    = 2;
    localparam int MUL_CYCLES   = XLEN + 2;
    localparam int ALU_OPS      = 2 * (6 + NUM_RAND) + 2 * (16 + NUM_RAND)
                                  + 6 * NUM_RAND + 3 * 6 + 1;
    localparam int MUL_OPS      = 4 + NUM_MUL_RAND + 1;
    localparam int TEST_CYCLES  = RESET_CYCLES + OP_CYCLES * ALU_OPS
                                  + MUL_CYCLES * MUL_OPS;
    localparam int TIMEOUT_NS   = 2 * TEST_CYCLES * CLK_PERIOD + 1000;

    logic            clk;
    logic            rst;
    logic            start;
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] result;
    logic            done;
    logic            busy;

    int_alu_top dut0 (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Reference model, plain operators only
    function automatic logic [XLEN-1:0] model_result(alu_op_e op_in,
                                                     logic [XLEN-1:0] x,
                                                     logic [XLEN-1:0] y);
        int              sh;
        logic [XLEN-1:0] fill;
        sh = int'(y[SHAMT_W-1:0]);
        // Ones in the vacated top bits for a negative SRA operand
        fill = x[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
        case (op_in)
            OP_ADD:  return x + y;
            OP_SUB:  return x - y;
            OP_SLT:  return ($signed(x) < $signed(y)) ? XLEN'(1) : '0;
            OP_SLTU: return (x < y) ? XLEN'(1) : '0;
            OP_AND:  return x & y;
            OP_OR:   return x | y;
            OP_XOR:  return x ^ y;
            OP_SLL:  return x << sh;
            OP_SRL:  return x >> sh;
            OP_SRA:  return (x >> sh) | fill;
            OP_MUL:  return x * y;
            default: return '0;
        endcase
    endfunction

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_on_failure();
    endtask

    task automatic check_result(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_latency(input int exp, input int got);
        if (got != exp) begin
            $display("CHECK FAILED done latency: got 0x%0h expected 0x%0h", got, exp);
            stop_on_failure();
        end
    endtask

    // Issue one request and count falling edges until done
    task automatic run_op(input alu_op_e op_in, input logic [XLEN-1:0] a_in,
                          input logic [XLEN-1:0] b_in, output int cycles);
        @(negedge clk);
        // Previous done must already be gone
        check_flag("done before start", done, 1'b0);
        start = 1'b1;
        op    = op_in;
        a     = a_in;
        b     = b_in;
        @(posedge clk);
        @(negedge clk);
        start  = 1'b0;
        cycles = 1;
        while (!done) begin
            check_flag("busy", busy, 1'b1);
            if (cycles > MAX_WAIT) begin
                report_failure("Timed out waiting for done");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic exec_check(input alu_op_e op_in, input logic [XLEN-1:0] a_in,
                              input logic [XLEN-1:0] b_in);
        int cycles;
        run_op(op_in, a_in, b_in, cycles);
        check_latency((op_in == OP_MUL) ? MUL_LATENCY : 1, cycles);
        check_flag("done", done, 1'b1);
        check_flag("busy", busy, 1'b0);
        check_result("result", result, model_result(op_in, a_in, b_in));
    endtask

    task automatic test_reset();
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag("done", done, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_result("result", result, '0);
    endtask

    task automatic test_add_sub();
        // Carry-wrapping pairs
        logic [XLEN-1:0] ea [6] = '{32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000,
                                    32'h0000_0000, 32'h0000_0000, 32'h8000_0000};
        logic [XLEN-1:0] eb [6] = '{32'h0000_0001, 32'h0000_0001, 32'h8000_0000,
                                    32'h0000_0001, 32'h0000_0000, 32'hffff_ffff};
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        for (int i = 0; i < 6; i++) begin
            exec_check(OP_ADD, ea[i], eb[i]);
            exec_check(OP_SUB, ea[i], eb[i]);
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            x = $urandom();
            y = $urandom();
            exec_check(OP_ADD, x, y);
            exec_check(OP_SUB, x, y);
        end
    endtask

    task automatic test_compare();
        // Zero, minus one, most negative, most positive
        logic [XLEN-1:0] bound [4] = '{32'h0000_0000, 32'hffff_ffff,
                                       32'h8000_0000, 32'h7fff_ffff};
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                exec_check(OP_SLT, bound[i], bound[j]);
                exec_check(OP_SLTU, bound[i], bound[j]);
            end
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            x = $urandom();
            y = $urandom();
            exec_check(OP_SLT, x, y);
            exec_check(OP_SLTU, x, y);
        end
    endtask

    task automatic test_logic_shift();
        // Amounts above 31 wrap to the low 5 bits
        logic [XLEN-1:0] amt [6] = '{32'd0, 32'd1, 32'd31, 32'd32, 32'd33, 32'd63};
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        for (int i = 0; i < 6; i++) begin
            exec_check(OP_SLL, 32'h8000_00f1, amt[i]);
            exec_check(OP_SRL, 32'h8000_00f1, amt[i]);
            exec_check(OP_SRA, 32'h8000_00f1, amt[i]);
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            x = $urandom();
            y = $urandom();
            exec_check(OP_AND, x, y);
            exec_check(OP_OR, x, y);
            exec_check(OP_XOR, x, y);
            exec_check(OP_SLL, x, y);
            exec_check(OP_SRL, x, y);
            exec_check(OP_SRA, x, y);
        end
    endtask

    task automatic test_mul();
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        exec_check(OP_MUL, 32'h0000_0000, 32'h1234_5678);
        exec_check(OP_MUL, 32'h0000_0001, 32'hffff_ffff);
        exec_check(OP_MUL, 32'hffff_ffff, 32'hffff_ffff);
        exec_check(OP_MUL, 32'h8000_0000, 32'h0000_0002);
        for (int i = 0; i < NUM_MUL_RAND; i++) begin
            x = $urandom();
            y = $urandom();
            exec_check(OP_MUL, x, y);
        end
    endtask

    task automatic test_busy_chain();
        logic [XLEN-1:0] ma;
        logic [XLEN-1:0] mb;
        logic [XLEN-1:0] xa;
        logic [XLEN-1:0] xb;
        int              cycles;
        ma = $urandom();
        mb = $urandom();
        xa = $urandom();
        xb = $urandom();
        @(negedge clk);
        check_flag("done before start", done, 1'b0);
        start = 1'b1;
        op    = OP_MUL;
        a     = ma;
        b     = mb;
        @(posedge clk);
        @(negedge clk);
        start  = 1'b0;
        cycles = 1;
        while (!done) begin
            check_flag("busy", busy, 1'b1);
            // Requests during the multiply must be dropped
            if (cycles == 4) begin
                start = 1'b1;
                op    = OP_ADD;
                a     = ~ma;
                b     = ~mb;
            end else if (cycles == 6) begin
                op = OP_MUL;
                a  = ma ^ 32'h5a5a_5a5a;
            end else if (cycles == 8) begin
                start = 1'b0;
            end
            if (cycles > MAX_WAIT) begin
                report_failure("Timed out waiting for multiply done");
            end
            @(negedge clk);
            cycles++;
        end
        check_latency(MUL_LATENCY, cycles);
        check_flag("busy", busy, 1'b0);
        check_result("result", result, model_result(OP_MUL, ma, mb));
        // New request in the done cycle itself
        start = 1'b1;
        op    = OP_XOR;
        a     = xa;
        b     = xb;
        @(posedge clk);
        @(negedge clk);
        start = 1'b0;
        check_flag("done", done, 1'b1);
        check_flag("busy", busy, 1'b0);
        check_result("result", result, model_result(OP_XOR, xa, xb));
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Run exceeded the time limit of %0d ns", TIMEOUT_NS);
        stop_on_failure();
    end

    initial begin
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        op    = OP_ADD;
        a     = '0;
        b     = '0;
        void'($urandom(SEED));
        test_reset();
        test_add_sub();
        test_compare();
        test_logic_shift();
        test_mul();
        test_busy_chain();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* int_alu_top.sv */
// Integer execution unit top level
// Control FSM plus add/sub, shift/logic and multiply datapaths
// Start strobe in, registered result with a one-cycle done pulse out

`timescale 1ns/1ps

module int_alu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  alu_pkg::alu_op_e         op,
    input  logic [alu_pkg::XLEN-1:0] a,
    input  logic [alu_pkg::XLEN-1:0] b,
    output logic [alu_pkg::XLEN-1:0] result,
    output logic                     done,
    output logic                     busy
);
    import alu_pkg::*;

    logic [XLEN-1:0] add_result;
    logic [XLEN-1:0] sl_result;
    logic [XLEN-1:0] mul_result;
    logic            mul_start;
    logic            mul_done;

    // Sequencing and result register
    alu_ctrl ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .add_result (add_result),
        .sl_result  (sl_result),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .mul_start  (mul_start),
        .result     (result),
        .done       (done),
        .busy       (busy)
    );

    // Add, sub and compares
    addsub_unit addsub0 (
        .op         (op),
        .a          (a),
        .b          (b),
        .add_result (add_result)
    );

    // Shifts and bitwise ops
    shift_logic_unit sl0 (
        .op        (op),
        .a         (a),
        .b         (b),
        .sl_result (sl_result)
    );

    // Multi-cycle multiply, operands held internally
    mul_unit mul0 (
        .clk        (clk),
        .rst        (rst),
        .mul_start  (mul_start),
        .a          (a),
        .b          (b),
        .mul_done   (mul_done),
        .mul_result (mul_result)
    );

endmodule

/* ks_adder.sv */
// Kogge-Stone parallel-prefix adder
// Generate/propagate pairs merged over log2(N) levels, carry in folded
// at the end; BYPASS swaps in a plain behavioral add

`timescale 1ns/1ps

module ks_adder #(
    parameter int N      = 32,
    parameter bit BYPASS = 1'b0
) (
    input  logic [N-1:0] dataa,
    input  logic [N-1:0] datab,
    input  logic         cin,
    output logic [N-1:0] sum,
    output logic         cout
);

    if (BYPASS) begin : g_bypass

        // Let synthesis pick the adder
        assign {cout, sum} = {1'b0, dataa} + {1'b0, datab} + (N+1)'(cin);

    end else begin : g_prefix

        localparam int LEVELS = $clog2(N);

        // Group generate and propagate, one row per level
        logic [N-1:0] gen [LEVELS+1];
        logic [N-1:0] prop [LEVELS+1];

        always_comb begin
            // Bit-level terms
            gen[0]  = dataa & datab;
            prop[0] = dataa ^ datab;
            for (int k = 1; k <= LEVELS; k++) begin
                for (int i = 0; i < N; i++) begin
                    // Span doubles every level
                    if (i >= (1 << (k - 1))) begin
                        gen[k][i]  = gen[k-1][i] |
                                     (prop[k-1][i] & gen[k-1][i - (1 << (k - 1))]);
                        prop[k][i] = prop[k-1][i] & prop[k-1][i - (1 << (k - 1))];
                    end else begin
                        gen[k][i]  = gen[k-1][i];
                        prop[k][i] = prop[k-1][i];
                    end
                end
            end
        end

        // Bit 0 sees only the carry in
        assign sum[0] = prop[0][0] ^ cin;

        for (genvar i = 1; i < N; i++) begin : g_sum
            // Carry into bit i from the prefix over bits i-1..0
            assign sum[i] = prop[0][i] ^ (gen[LEVELS][i-1] | (prop[LEVELS][i-1] & cin));
        end

        assign cout = gen[LEVELS][N-1] | (prop[LEVELS][N-1] & cin);

    end

endmodule

/* mul_unit.sv */
// Iterative shift-add multiplier
// One multiplier bit per cycle, XLEN cycles, low half of the product only
// Partial products accumulate through a Kogge-Stone adder

`timescale 1ns/1ps

module mul_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mul_start,
    input  logic [alu_pkg::XLEN-1:0] a,
    input  logic [alu_pkg::XLEN-1:0] b,
    output logic                     mul_done,
    output logic [alu_pkg::XLEN-1:0] mul_result
);
    import alu_pkg::*;

    logic               running;
    logic [SHAMT_W-1:0] iter_cnt;
    logic [XLEN-1:0]    mcand;
    logic [XLEN-1:0]    mplier;
    logic [XLEN-1:0]    acc;
    logic [XLEN-1:0]    addend;
    logic [XLEN-1:0]    acc_next;

    // Skip the partial product when the multiplier bit is clear
    assign addend = mplier[0] ? mcand : '0;

    // Carry out dropped, only the low half is kept
    ks_adder #(
        .N      (XLEN),
        .BYPASS (1'b0)
    ) adder0 (
        .dataa (acc),
        .datab (addend),
        .cin   (1'b0),
        .sum   (acc_next),
        .cout  ()
    );

    // Control
    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            iter_cnt <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                running  <= 1'b1;
                iter_cnt <= '0;
            end else if (running) begin
                iter_cnt <= iter_cnt + 1'b1;
                // Last iteration, acc final after this edge
                if (iter_cnt == SHAMT_W'(XLEN - 1)) begin
                    running  <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    // Operand and accumulator registers
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (running) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign mul_result = acc;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the integer ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module int_alu_tb \
    -f files.f

./obj_dir/Vint_alu_tb

/* shift_logic_unit.sv */
// Barrel shifter and bitwise logic unit
// Shift amount taken from the low bits of b, upper bits ignored

`timescale 1ns/1ps

module shift_logic_unit (
    input  alu_pkg::alu_op_e        op,
    input  logic [alu_pkg::XLEN-1:0] a,
    input  logic [alu_pkg::XLEN-1:0] b,
    output logic [alu_pkg::XLEN-1:0] sl_result
);
    import alu_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    sll_val;
    logic [XLEN-1:0]    srl_val;
    logic [XLEN-1:0]    sra_val;

    // Only the low bits count, like RISC-V shifts
    assign shamt = b[SHAMT_W-1:0];

    assign sll_val = a << shamt;
    assign srl_val = a >> shamt;

    // Sign fill from the top bit of a
    assign sra_val = $unsigned($signed(a) >>> shamt);

    always_comb begin
        case (op)
            OP_AND: sl_result = a & b;
            OP_OR:  sl_result = a | b;
            OP_XOR: sl_result = a ^ b;
            OP_SLL: sl_result = sll_val;
            OP_SRL: sl_result = srl_val;
            OP_SRA: sl_result = sra_val;
            // Adder ops and MUL handled elsewhere
            default: sl_result = '0;
        endcase
    end

endmodule
